//--- filelist.f
+incdir+source
source/board_pkg.sv
source/slow_tick_gen.sv
source/i2s_mic_receiver.sv
source/lab_top.sv
source/tm1638_controller.sv
source/board_top.sv
bench/board_checker.sv
bench/tb_board_top.sv

//--- Makefile
.PHONY: sim clean

# the run passes only when the log holds the pass line
sim:
	verilator --binary --timing -Wno-fatal --top-module tb_board_top \
		-f filelist.f -Mdir obj_dir -o sim_board
	./obj_dir/sim_board | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_board_top.sv
`timescale 1ns/100ps
`include "board_config.svh"

module tb_board_top;

    localparam int CLK_PERIOD   = 100;
    localparam int FRAME_CYCLES = 21 * 8 * 2 * `TM_SIO_HALF + 4 * 64;  // bytes plus gaps
    localparam int FRAMES_TO_RUN = 30;

    logic        clk;
    logic        rst;
    logic        sio_clk;
    logic        sio_stb;
    logic        sio_dout;
    logic        sio_doe;
    logic        sio_din;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;
    logic        mic_sd;

    integer      seed;
    logic [31:0] rnd;
    logic [23:0] mic_word;                      // sample the mic is sending now
    int          mic_pos;
    logic        mic_ws_prev;
    logic [7:0]  tm_byte;
    logic [7:0]  key_val;
    logic [7:0]  rd_byte;
    int          errors;
    int          frames;

    board_top board_top_inst
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_dout ( sio_dout ),
        .sio_doe  ( sio_doe  ),
        .sio_din  ( sio_din  ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   )
    );

    board_checker checker_inst
    (
        .clk            ( clk      ),
        .rst            ( rst      ),
        .sio_clk        ( sio_clk  ),
        .sio_stb        ( sio_stb  ),
        .sio_dout       ( sio_dout ),
        .sio_doe        ( sio_doe  ),
        .sio_din        ( sio_din  ),
        .mic_sck        ( mic_sck  ),
        .mic_ws         ( mic_ws   ),
        .mic_lr         ( mic_lr   ),
        .mic_sd         ( mic_sd   ),
        .errors         ( errors   ),
        .frames_checked ( frames   )
    );

    // ==============================
    // clock and reset
    // ==============================

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        seed    = 32'h1e20_0662;
        rst     = 1'b1;
        sio_din = 1'b0;
        mic_sd  = 1'b0;
        repeat (8) @(posedge clk);
        #5 rst = 1'b0;
    end

    // ==============================
    // I2S microphone model
    // ==============================

    initial
    begin
        mic_pos     = 0;
        mic_ws_prev = 1'b0;
        @(negedge rst);
        rnd      = $random(seed);
        mic_word = rnd[23:0];
        forever
        begin
            @(negedge mic_sck);
            #5;
            if (mic_ws_prev && !mic_ws)
            begin
                mic_pos  = 0;
                rnd      = $random(seed);
                mic_word = rnd[23:0];           // next left sample
            end
            else
                mic_pos++;
            mic_ws_prev = mic_ws;
            if (!mic_ws && mic_pos >= 1 && mic_pos <= 24)
                mic_sd = mic_word[24 - mic_pos];   // MSB first
            else
                mic_sd = 1'b0;
        end
    end

    // ==============================
    // TM1638 device model
    // ==============================

    initial
    begin
        @(negedge rst);
        forever
        begin
            @(negedge sio_stb);
            #5 sio_din = 1'b0;
            repeat (8)
            begin
                @(posedge sio_clk);
                tm_byte = {sio_dout, tm_byte[7:1]};
            end
            if (tm_byte == 8'h42)
            begin
                rnd     = $random(seed);
                key_val = rnd[7:0];
                for (int k = 0; k < 4; k++)
                begin
                    rd_byte = {3'b000, key_val[k + 4], 3'b000, key_val[k]};
                    for (int b = 0; b < 8; b++)
                    begin
                        @(negedge sio_clk);
                        #5 sio_din = rd_byte[b];
                    end
                end
            end
        end
    end

    // ==============================
    // end of run and watchdog
    // ==============================

    initial
    begin
        @(negedge rst);
        wait (frames >= FRAMES_TO_RUN);
        $display("errors: %0d, frames checked: %0d", errors, frames);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        #(40 * FRAME_CYCLES * CLK_PERIOD);
        $display("timeout: the display frames stopped coming after %0d frames", frames);
        $display("errors: %0d, frames checked: %0d", errors, frames);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- bench/board_checker.sv
`timescale 1ns/100ps
`include "board_config.svh"

module board_checker
(
    input            clk,
    input            rst,
    input            sio_clk,
    input            sio_stb,
    input            sio_dout,
    input            sio_doe,
    input            sio_din,
    input            mic_sck,
    input            mic_ws,
    input            mic_lr,
    input            mic_sd,
    output int       errors,
    output int       frames_checked
);

    int          cyc;
    int          mic_pos;
    logic        ws_prev;
    logic [23:0] shreg;
    logic [23:0] last_sample;
    logic [23:0] prev_sample;
    logic [23:0] exp_cur;
    logic [23:0] exp_old;
    logic [7:0]  exp_tick;
    logic [7:0]  exp_leds;
    logic [7:0]  next_keys;
    logic [7:0]  cur_byte;
    logic [7:0]  grp_bytes [0:16];
    int          nbits;
    int          nbytes;
    int          grp;
    logic [63:0] act_digits;
    logic [63:0] ref_a;
    logic [63:0] ref_b;

    // standard hex glyphs in abcdefgh order
    function automatic logic [7:0] glyph(input logic [3:0] nib);
        logic [7:0] tbl [0:15];
        tbl = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
                8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E};
        return tbl[nib];
    endfunction

    // digit bytes in wire order with segment a in bit 0
    function automatic logic [63:0] render(input logic [23:0] s, input logic [7:0] t);
        logic [31:0] nibs;
        logic [63:0] r;
        logic [7:0]  g;
        nibs = {s, t};
        for (int d = 0; d < 8; d++)
        begin
            g = glyph(nibs[4 * d +: 4]);
            for (int i = 0; i < 8; i++)
                r[8 * d + i] = g[7 - i];
        end
        return r;
    endfunction

    task automatic value_check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act)
        begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    initial
    begin
        errors         = 0;
        frames_checked = 0;
        @(negedge rst);
        value_check("sio_stb", 1, sio_stb);     // pins right after reset
        value_check("sio_clk", 1, sio_clk);
        value_check("sio_doe", 0, sio_doe);
        value_check("mic_sck", 0, mic_sck);
        value_check("mic_ws", 0, mic_ws);
        value_check("mic_lr", 0, mic_lr);
    end

    always @(posedge clk)
    begin
        if (rst)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // ==============================
    // I2S slot decoder
    // ==============================

    initial
    begin
        mic_pos     = 0;
        ws_prev     = 1'b0;
        shreg       = '0;
        last_sample = '0;
        prev_sample = '0;
        @(negedge rst);
        forever
        begin
            @(negedge mic_sck);
            #1;
            if (ws_prev && !mic_ws)
                mic_pos = 0;
            else
                mic_pos++;
            ws_prev = mic_ws;
        end
    end

    always @(posedge mic_sck)
    begin
        if (!rst && !mic_ws && mic_pos >= 1 && mic_pos <= 24)
        begin
            shreg = {shreg[22:0], mic_sd};
            if (mic_pos == 24)
            begin
                prev_sample = last_sample;
                last_sample = shreg;
            end
        end
    end

    // ==============================
    // TM1638 group decoder
    // ==============================

    always @(posedge sio_clk)
    begin
        if (sio_stb === 1'b0)
        begin
            cur_byte = {(sio_doe ? sio_dout : sio_din), cur_byte[7:1]};   // LSB first
            nbits++;
            if (nbits == 8)
            begin
                nbits = 0;
                if (nbytes < 17)
                    grp_bytes[nbytes] = cur_byte;
                nbytes++;
            end
        end
    end

    initial
    begin
        grp       = 0;
        next_keys = '0;
        @(negedge rst);
        forever
        begin
            @(negedge sio_stb);
            nbits  = 0;
            nbytes = 0;
            if (grp == 0)
            begin
                exp_cur  = last_sample;         // frame start snapshot
                exp_old  = prev_sample;
                exp_tick = 8'(cyc / `SLOW_TICK_CYCLES);
                exp_leds = next_keys;
            end
            @(posedge sio_stb);
            case (grp)
                0:
                begin
                    value_check("write command bytes", 1, nbytes);
                    value_check("write command", 8'h40, grp_bytes[0]);
                end
                1:
                begin
                    value_check("address group bytes", 17, nbytes);
                    value_check("address command", 8'hC0, grp_bytes[0]);
                    for (int d = 0; d < 8; d++)
                    begin
                        act_digits[8 * d +: 8] = grp_bytes[1 + 2 * d];
                        value_check($sformatf("led byte %0d", d), {7'd0, exp_leds[d]},
                                    grp_bytes[2 + 2 * d]);
                    end
                    ref_a = render(exp_cur, exp_tick);
                    ref_b = render(exp_old, exp_tick - 8'd1);
                    // one frame of slack on the sample and one tick on the counter
                    if (act_digits[63:16] !== ref_b[63:16])
                        value_check("digits 7..2", ref_a[63:16], act_digits[63:16]);
                    if (act_digits[15:0] !== ref_b[15:0])
                        value_check("digits 1..0", ref_a[15:0], act_digits[15:0]);
                end
                2:
                begin
                    value_check("display command bytes", 1, nbytes);
                    value_check("display command", 8'h8F, grp_bytes[0]);
                end
                default:
                begin
                    value_check("read group bytes", 5, nbytes);
                    value_check("read command", 8'h42, grp_bytes[0]);
                    for (int k = 0; k < 4; k++)
                    begin
                        next_keys[k]     = grp_bytes[k + 1][0];
                        next_keys[k + 4] = grp_bytes[k + 1][4];
                    end
                    frames_checked++;
                end
            endcase
            grp = (grp + 1) % 4;
        end
    end

endmodule

//--- source/board_top.sv
`timescale 1ns/100ps
`include "board_config.svh"

module board_top
(
    input        clk,
    input        rst,

    output       sio_clk,
    output       sio_stb,
    output       sio_dout,
    output       sio_doe,
    input        sio_din,

    output       mic_sck,
    output       mic_ws,
    output       mic_lr,
    input        mic_sd
);

    import board_pkg::*;

    logic                                tick;
    mic_sample_t                         sample;
    logic                                sample_valid;
    logic         [`W_TM_KEY   - 1:0]    keys;
    seg_pattern_t [`W_TM_DIGIT - 1:0]    digit_seg;
    logic         [`W_TM_LED   - 1:0]    led;

    // ==============================
    // sources
    // ==============================

    slow_tick_gen i_slow_tick_gen
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .tick         ( tick         )
    );

    i2s_mic_receiver i_microphone
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .lr           ( mic_lr       ),
        .sd           ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    // ==============================
    // lab and display
    // ==============================

    lab_top i_lab_top
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .tick         ( tick         ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .keys         ( keys         ),
        .digit_seg    ( digit_seg    ),
        .led          ( led          )
    );

    tm1638_controller i_tm1638
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .digit_seg    ( digit_seg    ),
        .led          ( led          ),
        .keys         ( keys         ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_dout     ( sio_dout     ),
        .sio_doe      ( sio_doe      ),
        .sio_din      ( sio_din      )
    );

endmodule

//--- source/tm1638_controller.sv
`timescale 1ns/100ps
`include "board_config.svh"

module tm1638_controller
(
    input                                                clk,
    input                                                rst,
    input  board_pkg::seg_pattern_t [`W_TM_DIGIT - 1:0]  digit_seg,
    input        [`W_TM_LED - 1:0]                       led,
    output logic [`W_TM_KEY - 1:0]                       keys,
    output logic                                         sio_clk,
    output logic                                         sio_stb,
    output logic                                         sio_dout,
    output logic                                         sio_doe,
    input                                                sio_din
);

    import board_pkg::*;

    localparam int GAP_CYCLES = 16;             // sio_stb high time between groups
    localparam int W_TMR      = $clog2(GAP_CYCLES + `TM_SIO_HALF);

    localparam logic [2:0] ST_GAP  = 3'd0,
                           ST_LEAD = 3'd1,
                           ST_LOW  = 3'd2,
                           ST_HIGH = 3'd3,
                           ST_TAIL = 3'd4;

    logic         [2:0]               state;
    logic         [W_TMR - 1:0]       tmr;
    logic                             tmr_done;
    logic         [1:0]               grp;      // command group within the frame
    logic         [4:0]               byt;      // byte within the group
    logic         [2:0]               bit_idx;
    logic         [7:0]               tx_q;
    logic         [7:0]               rx_q;
    seg_pattern_t [`W_TM_DIGIT - 1:0] seg_q;
    logic         [`W_TM_LED - 1:0]   led_q;
    logic         [`W_TM_KEY - 1:0]   keys_acc;
    logic         [`W_TM_KEY - 1:0]   keys_nxt;
    logic         [7:0]               cmd_byte;
    logic         [7:0]               data_byte;
    logic         [1:0]               rd_idx;
    logic                             last_byte;

    // the chip wants segment a in bit 0
    function automatic logic [7:0] to_hgfedcba(input seg_pattern_t seg);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
        begin
            r[i] = seg[7 - i];
        end
        return r;
    endfunction

    // ==============================
    // byte selection
    // ==============================

    always_comb
    begin
        case (grp)
            2'd0:    cmd_byte = 8'h40;          // write, auto increment
            2'd1:    cmd_byte = 8'hC0;          // start at address 0
            2'd2:    cmd_byte = 8'h8F;          // display on, full brightness
            default: cmd_byte = 8'h42;          // read keys
        endcase
    end

    always_comb
    begin
        case (grp)
            2'd1:    last_byte = (byt == 5'd16);
            2'd3:    last_byte = (byt == 5'd4);
            default: last_byte = 1'b1;
        endcase
    end

    // even addresses take a digit pattern and odd ones an LED
    assign data_byte = byt[0] ? {7'd0, led_q[byt[3:1]]} : to_hgfedcba(seg_q[byt[3:1]]);

    // read byte k carries key k in bit 0 and key k+4 in bit 4
    assign rd_idx = 2'(byt - 5'd1);

    always_comb
    begin
        keys_nxt                  = keys_acc;
        keys_nxt[{1'b0, rd_idx}] = rx_q[0];
        keys_nxt[{1'b1, rd_idx}] = rx_q[4];
    end

    assign tmr_done = (tmr == '0);

    // ==============================
    // frame sequencer and shifter
    // ==============================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_GAP;
            tmr      <= W_TMR'(GAP_CYCLES - 1);
            grp      <= '0;
            byt      <= '0;
            bit_idx  <= '0;
            keys_acc <= '0;
            keys     <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_dout <= 1'b0;
            sio_doe  <= 1'b0;
        end
        else if (!tmr_done)
            tmr <= tmr - 1'b1;
        else
        begin
            tmr <= W_TMR'(`TM_SIO_HALF - 1);

            case (state)
                ST_GAP:
                begin
                    sio_stb <= 1'b0;            // open the next command group
                    sio_doe <= 1'b1;
                    tx_q    <= cmd_byte;
                    byt     <= '0;
                    state   <= ST_LEAD;
                end
                ST_LEAD:
                begin
                    sio_clk  <= 1'b0;
                    sio_dout <= tx_q[0];        // LSB goes out first
                    state    <= ST_LOW;
                end
                ST_LOW:
                begin
                    sio_clk <= 1'b1;
                    rx_q    <= {sio_din, rx_q[7:1]};
                    state   <= ST_HIGH;
                end
                ST_HIGH:
                begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx != 3'd7)
                    begin
                        tx_q     <= {1'b0, tx_q[7:1]};
                        sio_clk  <= 1'b0;
                        sio_dout <= tx_q[1];
                        state    <= ST_LOW;
                    end
                    else
                    begin
                        if (grp == 2'd3 && byt != 5'd0)
                            keys_acc <= keys_nxt;

                        if (last_byte)
                        begin
                            if (grp == 2'd3)
                                keys <= keys_nxt;   // all four read bytes are in
                            state <= ST_TAIL;
                        end
                        else if (grp == 2'd1)
                        begin
                            byt      <= byt + 1'b1;
                            tx_q     <= data_byte;
                            sio_clk  <= 1'b0;
                            sio_dout <= data_byte[0];
                            state    <= ST_LOW;
                        end
                        else
                        begin
                            // let go of the data line, the chip drives it for reads
                            byt     <= byt + 1'b1;
                            sio_doe <= 1'b0;
                            state   <= ST_LEAD;
                        end
                    end
                end
                ST_TAIL:
                begin
                    sio_stb <= 1'b1;
                    sio_doe <= 1'b0;
                    grp     <= grp + 1'b1;      // wraps to the next frame
                    tmr     <= W_TMR'(GAP_CYCLES - 1);
                    state   <= ST_GAP;
                end
                default:
                    state <= ST_GAP;
            endcase
        end
    end

    // the frame shows what the lab drove when it started
    always_ff @(posedge clk)
    begin
        if (state == ST_GAP && tmr_done && grp == 2'd0)
        begin
            seg_q <= digit_seg;
            led_q <= led;
        end
    end

endmodule

//--- source/lab_top.sv
`timescale 1ns/100ps
`include "board_config.svh"

module lab_top
(
    input                                                clk,
    input                                                rst,
    input                                                tick,
    input  board_pkg::mic_sample_t                       sample,
    input                                                sample_valid,
    input        [`W_TM_KEY - 1:0]                       keys,
    output board_pkg::seg_pattern_t [`W_TM_DIGIT - 1:0]  digit_seg,
    output logic [`W_TM_LED - 1:0]                       led
);

    import board_pkg::*;

    mic_sample_t                      sample_q;
    mic_sample_t                      sample_nxt;
    logic         [7:0]               tick_cnt;
    logic         [7:0]               tick_cnt_nxt;
    seg_pattern_t [`W_TM_DIGIT - 1:0] digit_nxt;

    // usual hex glyphs, the decimal point stays dark
    function automatic seg_pattern_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 8'hFC;
            4'h1:    return 8'h60;
            4'h2:    return 8'hDA;
            4'h3:    return 8'hF2;
            4'h4:    return 8'h66;
            4'h5:    return 8'hB6;
            4'h6:    return 8'hBE;
            4'h7:    return 8'hE0;
            4'h8:    return 8'hFE;
            4'h9:    return 8'hF6;
            4'hA:    return 8'hEE;
            4'hB:    return 8'h3E;
            4'hC:    return 8'h9C;
            4'hD:    return 8'h7A;
            4'hE:    return 8'h9E;
            default: return 8'h8E;
        endcase
    endfunction

    assign sample_nxt   = sample_valid ? sample : sample_q;
    assign tick_cnt_nxt = tick_cnt + 8'(tick);

    // the counter sits on digits 1..0 and the sample on digits 7..2
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            digit_nxt[i] = hex_to_seg(tick_cnt_nxt[i * 4 +: 4]);
        end
        for (int i = 2; i < `W_TM_DIGIT; i++)
        begin
            digit_nxt[i] = hex_to_seg(sample_nxt[(i - 2) * 4 +: 4]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sample_q  <= '0;
            tick_cnt  <= '0;
            digit_seg <= {`W_TM_DIGIT{hex_to_seg(4'h0)}};
            led       <= '0;
        end
        else
        begin
            sample_q  <= sample_nxt;
            tick_cnt  <= tick_cnt_nxt;
            digit_seg <= digit_nxt;             // shows up one cycle after a strobe
            led       <= keys;
        end
    end

endmodule

//--- source/i2s_mic_receiver.sv
`timescale 1ns/100ps
`include "board_config.svh"

module i2s_mic_receiver
(
    input                           clk,
    input                           rst,
    output logic                    sck,
    output logic                    ws,
    output                          lr,
    input                           sd,
    output board_pkg::mic_sample_t  sample,
    output logic                    sample_valid
);

    import board_pkg::*;

    localparam int W_DIV       = $clog2(`I2S_SCK_HALF + 1);
    localparam int W_BIT       = $clog2(2 * `I2S_SLOT_BITS);
    localparam int SAMPLE_BITS = $bits(mic_sample_t);

    logic [W_DIV - 1:0] div_cnt;
    logic [W_BIT - 1:0] bit_cnt;
    logic [W_BIT - 1:0] bit_cnt_nxt;
    logic               half_done;
    logic               sck_rise;
    logic               sck_fall;
    logic               in_sample;
    mic_sample_t        shift_q;

    assign lr = 1'b0;                           // the mic answers in the left slot

    assign half_done   = (div_cnt == W_DIV'(`I2S_SCK_HALF - 1));
    assign sck_rise    = half_done & ~sck;
    assign sck_fall    = half_done & sck;
    assign bit_cnt_nxt = bit_cnt + 1'b1;

    // MSB comes one sck period after ws falls, then 23 more bits
    assign in_sample = ~ws && (bit_cnt >= W_BIT'(1)) && (bit_cnt <= W_BIT'(SAMPLE_BITS));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt      <= '0;
            sck          <= 1'b0;
            bit_cnt      <= '0;
            ws           <= 1'b0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;
            div_cnt      <= half_done ? '0 : div_cnt + 1'b1;

            if (half_done)
                sck <= ~sck;

            // ws and the bit count move with the falling edge, as the mic does
            if (sck_fall)
            begin
                bit_cnt <= bit_cnt_nxt;
                ws      <= (bit_cnt_nxt >= W_BIT'(`I2S_SLOT_BITS));
            end

            if (sck_rise && in_sample)
            begin
                shift_q <= {shift_q[SAMPLE_BITS - 2:0], sd};
                if (bit_cnt == W_BIT'(SAMPLE_BITS))
                begin
                    sample       <= {shift_q[SAMPLE_BITS - 2:0], sd};
                    sample_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/slow_tick_gen.sv
`timescale 1ns/100ps
`include "board_config.svh"

module slow_tick_gen
(
    input              clk,
    input              rst,
    output logic       tick
);

    localparam int W_CNT = $clog2(`SLOW_TICK_CYCLES);

    logic [W_CNT - 1:0] cnt;
    logic               wrap;

    assign wrap = (cnt == W_CNT'(`SLOW_TICK_CYCLES - 1));

    // a clock enable stands in for the board's slow clock
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;                       // one cycle per period
        end
    end

endmodule

//--- source/board_pkg.sv
package board_pkg;

    // signed microphone sample, the INMP441 sends it MSB first
    typedef logic signed [23:0] mic_sample_t;

    // one bit per segment in abcdefgh order
    // bit 7 is segment a and bit 0 is the decimal point
    typedef logic [7:0] seg_pattern_t;

endpackage

//--- source/board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ==============================
// clocking
// ==============================

`define BOARD_CLK_MHZ        10

// one slow tick per millisecond at the board clock
`define SLOW_TICK_CYCLES     (`BOARD_CLK_MHZ * 1000)

// ==============================
// serial interfaces
// ==============================

`define TM_SIO_HALF          4     // clock cycles per sio_clk half period
`define I2S_SCK_HALF         4     // clock cycles per sck half period
`define I2S_SLOT_BITS        32    // sck periods in each ws half

// ==============================
// display module widths
// ==============================

`define W_TM_DIGIT           8
`define W_TM_LED             8
`define W_TM_KEY             8

`endif
